/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        NOP    = 7'b0000000,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        REG,
        FROM_MEM,
        FROM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
        logic mem_read;
        logic mem_write;
        logic alu_src;
        logic is_branch;
        logic is_jal;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus4;
    } if_id_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc_plus4;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic            funct7_5;
    } id_ex_t;

    typedef struct packed {
        logic            reg_write;
        logic            mem_to_reg;
        logic            mem_read;
        logic            mem_write;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        logic            mem_to_reg;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] load_data;
        logic [4:0]      rd;
    } mem_wb_t;

    // caches hold big-endian words
    function automatic logic [XLEN-1:0] bswap32(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic [31:0] rd_data_i,
    input  logic        we_i,
    output logic [31:0] rs1_data_o,
    output logic [31:0] rs2_data_o
);

    logic [31:0] regs [32];
    logic        wr_en;

    // x0 is never written
    assign wr_en = we_i && !rst_i && rd_i != 5'd0;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // same-cycle write shows through on the read side
    always_comb begin
        rs1_data_o = (rs1_i == 5'd0) ? 32'd0 :
                     (wr_en && rd_i == rs1_i) ? rd_data_i : regs[rs1_i];
        rs2_data_o = (rs2_i == 5'd0) ? 32'd0 :
                     (wr_en && rd_i == rs2_i) ? rd_data_i : regs[rs2_i];
    end

endmodule

`default_nettype wire

/* logic/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           freeze_i,
    input  logic           hold_i,
    input  logic           redirect_i,
    input  logic [31:0]    redirect_pc_i,
    input  logic           squash_i,
    input  logic [31:0]    instr_i,
    output logic [31:0]    pc_o,
    output rv_pkg::if_id_t if_id_o
);

    logic        stall;
    logic        is_jal;
    logic [31:0] jal_imm;
    logic [31:0] pc_plus4;
    logic [31:0] pc_next;

    assign stall    = freeze_i | hold_i;
    assign pc_plus4 = pc_o + 32'd4;

    // jal predecode, J-type immediate
    assign is_jal  = (instr_i[6:0] == rv_pkg::JAL);
    assign jal_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // taken branch in decode beats the jal fetched behind it
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;
        end else if (is_jal) begin
            pc_next = pc_o + jal_imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o    <= RESET_PC;
            if_id_o <= '0;
        end else if (!stall) begin
            pc_o             <= pc_next;
            if_id_o.instr    <= squash_i ? 32'd0 : instr_i;
            if_id_o.pc       <= pc_o;
            if_id_o.pc_plus4 <= pc_plus4;
        end
    end

    // jal and branch targets must keep word alignment
    assert property (@(posedge clk_i) disable iff (rst_i) pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           freeze_i,
    input  rv_pkg::if_id_t if_id_i,
    output logic [4:0]     rs1_o,
    output logic [4:0]     rs2_o,
    input  logic [31:0]    rs1_data_i,
    input  logic [31:0]    rs2_data_i,
    input  logic [4:0]     ex_fwd_rd_i,
    input  logic [31:0]    ex_fwd_data_i,
    input  logic           ex_fwd_we_i,
    input  logic           ex_is_load_i,
    input  logic [4:0]     mem_fwd_rd_i,
    input  logic [31:0]    mem_fwd_data_i,
    input  logic           mem_fwd_we_i,
    output logic           hold_o,
    output logic           redirect_o,
    output logic [31:0]    redirect_pc_o,
    output logic           squash_o,
    output rv_pkg::id_ex_t id_ex_o
);

    logic [31:0]     instr;
    rv_pkg::opcode_e opcode;
    rv_pkg::ctrl_t   ctrl;
    logic [31:0]     imm_i;
    logic [31:0]     imm_s;
    logic [31:0]     imm_b;
    logic [31:0]     imm_j;
    logic [31:0]     imm;
    logic            uses_rs1;
    logic            uses_rs2;
    logic [31:0]     op_a;
    logic [31:0]     op_b;
    logic            load_use;
    logic            branch_on_load;
    logic            branch_taken;
    logic            mem_is_load;

    // youngest producer wins, x0 never forwarded
    function automatic logic [31:0] fwd(input logic [4:0] rs, input logic [31:0] rf_data);
        if (ex_fwd_we_i && rs != 5'd0 && rs == ex_fwd_rd_i) begin
            return ex_fwd_data_i;
        end else if (mem_fwd_we_i && rs != 5'd0 && rs == mem_fwd_rd_i) begin
            return mem_fwd_data_i;
        end
        return rf_data;
    endfunction

    assign instr  = if_id_i.instr;
    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl     = '0;
        imm      = imm_i;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_pkg::OP: begin
                ctrl.reg_write = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                uses_rs1       = 1'b1;
            end
            rv_pkg::LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                uses_rs1        = 1'b1;
            end
            rv_pkg::STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm            = imm_s;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            rv_pkg::BRANCH: begin
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            rv_pkg::JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                imm            = imm_j;
            end
            default: ;
        endcase
    end

    always_comb begin
        op_a = fwd(rs1_o, rs1_data_i);
        op_b = fwd(rs2_o, rs2_data_i);
    end

    // load in EX feeding this instruction
    assign load_use = ex_is_load_i && ex_fwd_rd_i != 5'd0 &&
                      ((uses_rs1 && rs1_o == ex_fwd_rd_i) || (uses_rs2 && rs2_o == ex_fwd_rd_i));

    // a branch also waits out a load in MEM, its data is not in ex_mem yet
    assign branch_on_load = ctrl.is_branch && mem_is_load && mem_fwd_rd_i != 5'd0 &&
                            (rs1_o == mem_fwd_rd_i || rs2_o == mem_fwd_rd_i);

    assign hold_o = load_use | branch_on_load;

    // funct3[0] picks bne
    assign branch_taken  = ctrl.is_branch && ((op_a == op_b) != instr[12]);
    assign redirect_o    = branch_taken & ~hold_o;
    assign redirect_pc_o = if_id_i.pc + imm_b;
    assign squash_o      = redirect_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_is_load <= 1'b0;
            id_ex_o     <= '0;
        end else if (!freeze_i) begin
            mem_is_load <= ex_is_load_i;
            if (hold_o) begin
                id_ex_o <= '0;
            end else begin
                id_ex_o.ctrl     <= ctrl;
                id_ex_o.rs1_data <= op_a;
                id_ex_o.rs2_data <= op_b;
                id_ex_o.imm      <= imm;
                id_ex_o.pc_plus4 <= if_id_i.pc_plus4;
                id_ex_o.rs1      <= rs1_o;
                id_ex_o.rs2      <= rs2_o;
                id_ex_o.rd       <= instr[11:7];
                id_ex_o.funct3   <= instr[14:12];
                id_ex_o.funct7_5 <= instr[30];
            end
        end
    end

    // the slot fetched behind a taken branch comes back as a bubble
    assert property (@(posedge clk_i) disable iff (rst_i)
        (redirect_o && !freeze_i) |=> if_id_i.instr == 32'd0);

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            freeze_i,
    input  rv_pkg::id_ex_t  id_ex_i,
    input  logic [4:0]      mem_rd_i,
    input  logic            mem_we_i,
    input  logic [31:0]     mem_result_i,
    input  logic [4:0]      wb_rd_i,
    input  logic            wb_we_i,
    input  logic [31:0]     wb_data_i,
    output logic [31:0]     fwd_data_o,
    output rv_pkg::ex_mem_t ex_mem_o
);

    rv_pkg::fwd_sel_e sel_a;
    rv_pkg::fwd_sel_e sel_b;
    rv_pkg::alu_op_e  alu_op;
    logic [31:0]      op_a;
    logic [31:0]      rs2_val;
    logic [31:0]      op_b;
    logic [31:0]      alu_y;

    function automatic rv_pkg::fwd_sel_e pick(input logic [4:0] rs);
        if (mem_we_i && rs != 5'd0 && rs == mem_rd_i) begin
            return rv_pkg::FROM_MEM;
        end else if (wb_we_i && rs != 5'd0 && rs == wb_rd_i) begin
            return rv_pkg::FROM_WB;
        end
        return rv_pkg::REG;
    endfunction

    function automatic logic [31:0] sel_val(input rv_pkg::fwd_sel_e sel,
                                            input logic [31:0] rf_val);
        case (sel)
            rv_pkg::FROM_MEM: return mem_result_i;
            rv_pkg::FROM_WB:  return wb_data_i;
            default:          return rf_val;
        endcase
    endfunction

    always_comb begin
        sel_a   = pick(id_ex_i.rs1);
        sel_b   = pick(id_ex_i.rs2);
        op_a    = sel_val(sel_a, id_ex_i.rs1_data);
        rs2_val = sel_val(sel_b, id_ex_i.rs2_data);
        op_b    = id_ex_i.ctrl.alu_src ? id_ex_i.imm : rs2_val;
    end

    // only register ops look at funct3, everything else adds
    always_comb begin
        alu_op = rv_pkg::ADD;
        if (id_ex_i.ctrl.reg_write && !id_ex_i.ctrl.alu_src && !id_ex_i.ctrl.is_jal) begin
            case (id_ex_i.funct3)
                3'b000:  alu_op = id_ex_i.funct7_5 ? rv_pkg::SUB : rv_pkg::ADD;
                3'b010:  alu_op = rv_pkg::SLT;
                3'b110:  alu_op = rv_pkg::OR;
                3'b111:  alu_op = rv_pkg::AND;
                default: alu_op = rv_pkg::ADD;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            rv_pkg::SUB: alu_y = op_a - op_b;
            rv_pkg::AND: alu_y = op_a & op_b;
            rv_pkg::OR:  alu_y = op_a | op_b;
            rv_pkg::SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            default:     alu_y = op_a + op_b;
        endcase
    end

    // jal links pc+4
    assign fwd_data_o = id_ex_i.ctrl.is_jal ? id_ex_i.pc_plus4 : alu_y;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_o <= '0;
        end else if (!freeze_i) begin
            ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_to_reg <= id_ex_i.ctrl.mem_to_reg;
            ex_mem_o.mem_read   <= id_ex_i.ctrl.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
            ex_mem_o.result     <= fwd_data_o;
            ex_mem_o.store_data <= rs2_val;
            ex_mem_o.rd         <= id_ex_i.rd;
        end
    end

    // slt is 0 or 1, signs differ means op_a's sign decides
    assert property (@(posedge clk_i) disable iff (rst_i)
        (alu_op == rv_pkg::SLT) |->
            alu_y == {31'd0, ((op_a[31] != op_b[31]) ? op_a[31] : (op_a < op_b))});

endmodule

`default_nettype wire

/* logic/rv_memwb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memwb (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            freeze_i,
    input  rv_pkg::ex_mem_t ex_mem_i,
    output logic            dcache_ren_o,
    output logic            dcache_wen_o,
    output logic [29:0]     dcache_addr_o,
    output logic [31:0]     dcache_wdata_o,
    input  logic [31:0]     dcache_rdata_i,
    output logic [4:0]      wb_rd_o,
    output logic [31:0]     wb_data_o,
    output logic            wb_we_o
);

    rv_pkg::mem_wb_t mem_wb;

    // strobes are levels straight from ex_mem, held while frozen
    assign dcache_ren_o   = ex_mem_i.mem_read;
    assign dcache_wen_o   = ex_mem_i.mem_write;
    assign dcache_addr_o  = ex_mem_i.result[31:2];
    assign dcache_wdata_o = rv_pkg::bswap32(ex_mem_i.store_data);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_wb <= '0;
        end else if (!freeze_i) begin
            mem_wb.reg_write  <= ex_mem_i.reg_write;
            mem_wb.mem_to_reg <= ex_mem_i.mem_to_reg;
            mem_wb.result     <= ex_mem_i.result;
            mem_wb.load_data  <= rv_pkg::bswap32(dcache_rdata_i);
            mem_wb.rd         <= ex_mem_i.rd;
        end
    end

    assign wb_rd_o   = mem_wb.rd;
    assign wb_we_o   = mem_wb.reg_write;
    assign wb_data_o = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

    assert property (@(posedge clk_i) disable iff (rst_i) !(dcache_ren_o && dcache_wen_o));

endmodule

`default_nettype wire

/* logic/rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pipeline #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk_i,
    input  logic        rst_i,
    output logic        icache_ren_o,
    output logic [29:0] icache_addr_o,
    input  logic        icache_stall_i,
    input  logic [31:0] icache_rdata_i,
    output logic        dcache_ren_o,
    output logic        dcache_wen_o,
    output logic [29:0] dcache_addr_o,
    output logic [31:0] dcache_wdata_o,
    input  logic        dcache_stall_i,
    input  logic [31:0] dcache_rdata_i,
    output logic [31:0] pc_o
);

    logic              freeze;
    logic [31:0]       instr;
    logic              hold;
    logic              redirect;
    logic [31:0]       redirect_pc;
    logic              squash;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic [31:0]       ex_result;
    logic [4:0]        wb_rd;
    logic [31:0]       wb_data;
    logic              wb_we;
    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;

    // either cache stalling freezes every stage
    assign freeze = icache_stall_i | dcache_stall_i;

    assign icache_ren_o  = 1'b1;
    assign icache_addr_o = pc_o[31:2];
    assign instr         = rv_pkg::bswap32(icache_rdata_i);

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .freeze_i      (freeze),
        .hold_i        (hold),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .squash_i      (squash),
        .instr_i       (instr),
        .pc_o          (pc_o),
        .if_id_o       (if_id)
    );

    rv_decode u_decode (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .freeze_i       (freeze),
        .if_id_i        (if_id),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_fwd_rd_i    (id_ex.rd),
        .ex_fwd_data_i  (ex_result),
        .ex_fwd_we_i    (id_ex.ctrl.reg_write),
        .ex_is_load_i   (id_ex.ctrl.mem_read),
        .mem_fwd_rd_i   (ex_mem.rd),
        .mem_fwd_data_i (ex_mem.result),
        .mem_fwd_we_i   (ex_mem.reg_write),
        .hold_o         (hold),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .squash_o       (squash),
        .id_ex_o        (id_ex)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rd_i       (wb_rd),
        .rd_data_i  (wb_data),
        .we_i       (wb_we),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute u_execute (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .freeze_i     (freeze),
        .id_ex_i      (id_ex),
        .mem_rd_i     (ex_mem.rd),
        .mem_we_i     (ex_mem.reg_write),
        .mem_result_i (ex_mem.result),
        .wb_rd_i      (wb_rd),
        .wb_we_i      (wb_we),
        .wb_data_i    (wb_data),
        .fwd_data_o   (ex_result),
        .ex_mem_o     (ex_mem)
    );

    rv_memwb u_memwb (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .freeze_i       (freeze),
        .ex_mem_i       (ex_mem),
        .dcache_ren_o   (dcache_ren_o),
        .dcache_wen_o   (dcache_wen_o),
        .dcache_addr_o  (dcache_addr_o),
        .dcache_wdata_o (dcache_wdata_o),
        .dcache_rdata_i (dcache_rdata_i),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .wb_we_o        (wb_we)
    );

endmodule

`default_nettype wire

/* tests/tb_rv_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipeline;

    localparam logic [31:0] RESET_PC = 32'h0000_0040;
    localparam int NPROG = 26;
    localparam int NST   = 9;
    localparam int LIMIT = 40 * NPROG;
    // first sw is instruction 8 and reaches MEM three cycles after its fetch
    localparam int FIRST_WR_CYC = 8 + 3;
    localparam int OPI = 32'h13;
    localparam int LDO = 32'h03;
    // the only lw in the program reads this byte address
    localparam logic [31:0] LD_ADDR = 32'h0000_0004;

    logic        clk_i;
    logic        rst_i;
    logic        icache_ren_o;
    logic [29:0] icache_addr_o;
    logic        icache_stall_i;
    logic [31:0] icache_rdata_i;
    logic        dcache_ren_o;
    logic        dcache_wen_o;
    logic [29:0] dcache_addr_o;
    logic [31:0] dcache_wdata_o;
    logic        dcache_stall_i;
    logic [31:0] dcache_rdata_i;
    logic [31:0] pc_o;
    logic        freeze;
    logic        wr_fire;
    logic [31:0] prog [NPROG];
    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] exp_addr [NST];
    logic [31:0] exp_data [NST];
    int          exp_tag [NST];
    int          wr_idx;
    int          done_tag;
    int          run_cyc;
    int          err_cnt;
    int          err_base;
    int          tests_failed;

    rv_pipeline #(
        .RESET_PC(RESET_PC)
    ) DUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .icache_ren_o   (icache_ren_o),
        .icache_addr_o  (icache_addr_o),
        .icache_stall_i (icache_stall_i),
        .icache_rdata_i (icache_rdata_i),
        .dcache_ren_o   (dcache_ren_o),
        .dcache_wen_o   (dcache_wen_o),
        .dcache_addr_o  (dcache_addr_o),
        .dcache_wdata_o (dcache_wdata_o),
        .dcache_stall_i (dcache_stall_i),
        .dcache_rdata_i (dcache_rdata_i),
        .pc_o           (pc_o)
    );

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input int opc, input int f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset";
            2:       return "dependent alu ops";
            3:       return "load-use";
            4:       return "branches";
            5:       return "jal link";
            default: return "stall sequence";
        endcase
    endfunction

    // program, words at RESET_PC onward
    //  x1 = 25, x2 = -7, x3 = x1+x2 = 0x12, x4 = x3-x1 = 0xfffffff9
    //  x5 = x4 & x3 = 0x10, x6 = x5 | x1 = 0x19, x7 = (x4 < x6) = 1, x8 = x7+100 = 0x65
    //  lw x9 from 0x04 gives 0xfffffff9, x10 = x9+50 = 0x2b
    //  beq x11,x1 taken over the sw to 0x1c, bne x11,x6 not taken
    //  jal x12 at 0x98 skips the sw to 0x24, so x12 = 0x9c
    task automatic load_program();
        prog[0]  = itype(OPI, 0, 1, 0, 25);
        prog[1]  = itype(OPI, 0, 2, 0, -7);
        prog[2]  = rtype(0, 0, 3, 1, 2);
        prog[3]  = rtype(32, 0, 4, 3, 1);
        prog[4]  = rtype(0, 7, 5, 4, 3);
        prog[5]  = rtype(0, 6, 6, 5, 1);
        prog[6]  = rtype(0, 2, 7, 4, 6);
        prog[7]  = itype(OPI, 0, 8, 7, 100);
        prog[8]  = stype(8, 0, 20);
        prog[9]  = stype(3, 0, 0);
        prog[10] = stype(4, 0, 4);
        prog[11] = stype(5, 0, 8);
        prog[12] = stype(6, 0, 12);
        prog[13] = stype(7, 0, 16);
        prog[14] = itype(LDO, 2, 9, 0, 4);
        prog[15] = itype(OPI, 0, 10, 9, 50);
        prog[16] = stype(10, 0, 24);
        prog[17] = itype(OPI, 0, 11, 0, 25);
        prog[18] = btype(0, 11, 1, 8);
        prog[19] = stype(0, 0, 28);
        prog[20] = btype(1, 11, 6, 8);
        prog[21] = stype(11, 0, 32);
        prog[22] = jtype(12, 8);
        prog[23] = stype(0, 0, 36);
        prog[24] = stype(12, 0, 40);
        prog[25] = jtype(0, 0);
        // opcode field stays zero in the fill, so stray words decode as bubbles
        for (int i = 0; i < 64; i++) begin
            imem[i] = swap_bytes(32'(i) << 7);
            dmem[i] <= 32'h5a3c_0000 ^ (32'(i) * 32'h0101_0107);
        end
        for (int k = 0; k < NPROG; k++) begin
            imem[int'(RESET_PC[7:2]) + k] = swap_bytes(prog[k]);
        end
        exp_addr = '{32'h14, 32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h18, 32'h20, 32'h28};
        exp_data = '{32'h65, 32'h12, 32'hffff_fff9, 32'h10, 32'h19, 32'h1, 32'h2b, 32'h19,
                     32'h9c};
        exp_tag  = '{1, 0, 0, 0, 0, 2, 3, 4, 5};
    endtask

    task automatic report_test(input int n);
        int fails;
        fails    = err_cnt - err_base;
        err_base = err_cnt;
        if (fails == 0) begin
            $display("test %0d (%s): ok", n, test_name(n));
        end else begin
            $display("test %0d (%s): %0d check(s) failed", n, test_name(n), fails);
            tests_failed = tests_failed + 1;
        end
    endtask

    // caches answer combinationally, big-endian words
    // data side returns nothing without a read strobe
    assign icache_rdata_i = imem[icache_addr_o[5:0]];
    assign dcache_rdata_i = dcache_ren_o ? dmem[dcache_addr_o[5:0]] : 32'd0;
    assign freeze         = icache_stall_i | dcache_stall_i;
    assign wr_fire        = dcache_wen_o && !freeze && !rst_i;

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            icache_stall_i <= 1'b0;
            dcache_stall_i <= 1'b0;
        end else begin
            icache_stall_i <= ($urandom % 32'd6) == 32'd0;
            dcache_stall_i <= ($urandom % 32'd6) == 32'd0;
        end
    end

    // write commits only in a cycle where the pipeline moves
    always @(posedge clk_i) begin
        if (done_tag != 0) begin
            report_test(done_tag);
        end
        if (wr_fire) begin
            dmem[dcache_addr_o[5:0]] <= dcache_wdata_o;
            done_tag <= (wr_idx < NST) ? exp_tag[wr_idx] : 0;
            wr_idx   <= wr_idx + 1;
        end else begin
            done_tag <= 0;
        end
    end

    always @(posedge clk_i) begin
        run_cyc <= rst_i ? 0 : run_cyc + 1;
        if (run_cyc == LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d stores seen", LIMIT, wr_idx, NST);
            $display("Testbench failed");
            $finish;
        end
    end

    reset_pc_check: assert property (@(posedge clk_i) $fell(rst_i) |-> pc_o == RESET_PC)
        else begin
            $display("FAILED pc_o: got %h expected %h", $sampled(pc_o), RESET_PC);
            err_cnt = err_cnt + 1;
        end

    early_write_check: assert property (@(posedge clk_i) disable iff (rst_i)
        (run_cyc < FIRST_WR_CYC) |-> !dcache_wen_o)
        else begin
            $display("FAILED dcache_wen_o: got %h expected %h", 1'b1, 1'b0);
            err_cnt = err_cnt + 1;
        end

    icache_read_check: assert property (@(posedge clk_i) disable iff (rst_i) icache_ren_o)
        else begin
            $display("FAILED icache_ren_o: got %h expected %h", $sampled(icache_ren_o), 1'b1);
            err_cnt = err_cnt + 1;
        end

    read_addr_check: assert property (@(posedge clk_i) disable iff (rst_i)
        (dcache_ren_o && !freeze) |-> dcache_addr_o == LD_ADDR[31:2])
        else begin
            $display("FAILED dcache_addr_o on read: got %h expected %h",
                     $sampled(dcache_addr_o), LD_ADDR[31:2]);
            err_cnt = err_cnt + 1;
        end

    write_addr_check: assert property (@(posedge clk_i)
        wr_fire |-> (wr_idx >= NST || dcache_addr_o == exp_addr[wr_idx][31:2]))
        else begin
            $display("FAILED dcache_addr_o: got %h expected %h", $sampled(dcache_addr_o),
                     exp_addr[$sampled(wr_idx)][31:2]);
            err_cnt = err_cnt + 1;
        end

    write_data_check: assert property (@(posedge clk_i)
        wr_fire |-> (wr_idx >= NST || dcache_wdata_o == swap_bytes(exp_data[wr_idx])))
        else begin
            $display("FAILED dcache_wdata_o: got %h expected %h", $sampled(dcache_wdata_o),
                     swap_bytes(exp_data[$sampled(wr_idx)]));
            err_cnt = err_cnt + 1;
        end

    extra_write_check: assert property (@(posedge clk_i) wr_fire |-> wr_idx < NST)
        else begin
            $display("data cache write seen after the last expected store");
            err_cnt = err_cnt + 1;
        end

    initial begin
        int t6_fail;
        void'($urandom(77648));
        rst_i          = 1'b1;
        icache_stall_i = 1'b0;
        dcache_stall_i = 1'b0;
        load_program();
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        while (wr_idx < NST) @(posedge clk_i);
        // keep running so a late stray write is still caught
        repeat (12) @(posedge clk_i);
        t6_fail = (err_cnt != 0) ? 1 : 0;
        if (t6_fail == 0) begin
            $display("test 6 (%s): ok", test_name(6));
        end else begin
            $display("test 6 (%s): %0d check(s) failed", test_name(6), err_cnt);
        end
        $display("tests run 6, tests failed %0d, checks failed %0d",
                 tests_failed + t6_fail, err_cnt);
        if (tests_failed + t6_fail == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_memwb.sv
logic/rv_pipeline.sv
tests/tb_rv_pipeline.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rv_pipeline
FILELIST  = filelist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
